// File: bench/motion_core_properties.sv
// Motion core assertions

`timescale 1ns/10ps
`include "motion_cfg.svh"

module motion_core_properties (
  input logic                   CLK,
  input logic                   resetn,
  input logic [`NUM_MOTORS-1:0] step,
  input logic                   move_done,
  input logic                   buffer_dtr,
  input logic                   executing_move
);

  // End of move is a single-cycle event
  a_done_single: assert property (@(posedge CLK) disable iff (!resetn)
    move_done |=> !move_done)
    else $error("move_done stayed high for two cycles");

  // Steps follow a tick taken while a move runs
  a_step_in_move: assert property (@(posedge CLK) disable iff (!resetn)
    (|step) |-> $past(executing_move))
    else $error("step pulse without a running move");

  a_reset_state: assert property (@(posedge CLK)
    $rose(resetn) |-> (buffer_dtr && step == '0))
    else $error("buffer_dtr low or step high right after reset");

endmodule

bind motion_core_top motion_core_properties props_i (
  .CLK            (CLK),
  .resetn         (resetn),
  .step           (step),
  .move_done      (move_done),
  .buffer_dtr     (buffer_dtr),
  .executing_move (executing_move)
);

// File: bench/motion_core_tb.sv
// Motion core testbench

`timescale 1ns/10ps
`include "motion_cfg.svh"

module motion_core_tb;

  // 9 moves of up to 36 send and 90 run cycles plus register traffic and waits
  localparam int TIMEOUT_CYCLES = 20000;
  // Longest move at divisor 4 plus load and tick phase
  localparam int DROP_WAIT_CYCLES = 20 * 4 + 40;

  logic                   CLK;
  logic                   resetn;
  logic [`WORD_BITS-1:0]  word_data_received;
  logic                   word_received;
  logic [`WORD_BITS-1:0]  word_send_data;
  logic [`NUM_MOTORS-1:0] step;
  logic [`NUM_MOTORS-1:0] dir;
  logic [`NUM_MOTORS-1:0] enable;
  logic                   buffer_dtr;
  logic                   move_done;

  logic [31:0]            rng_state;
  logic [`NUM_MOTORS-1:0] dir_prev;   // Direction during the tick behind a step
  int model_pos [`NUM_MOTORS];
  int seen_steps [`NUM_MOTORS];
  int accepted;
  int done_count;
  int checks;
  int errors;
  int timeouts;
  int cycle_count;

  motion_core_top dut_i (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .word_send_data     (word_send_data),
    .step               (step),
    .dir                (dir),
    .enable             (enable),
    .buffer_dtr         (buffer_dtr),
    .move_done          (move_done)
  );

  always #2 CLK = ~CLK;

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Steps of one axis over a whole move
  function automatic int dda_steps(input logic [31:0] vel0, input logic [31:0] acc,
                                   input int dur);
    logic [31:0] vel;
    logic [31:0] accum;
    logic [32:0] sum;
    int          steps;
    vel   = vel0;
    accum = '0;
    steps = 0;
    for (int t = 0; t < dur; t++) begin
      vel = vel + acc;
      sum = {1'b0, accum} + {1'b0, vel};
      if (sum[32])
        steps++;
      accum = sum[31:0];
    end
    return steps;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d checks, %0d mismatches, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  endtask

  // Strobe high 3 cycles, reply read after the third edge, then low 3 cycles
  task automatic send_word(input logic [63:0] data, output logic [63:0] reply);
    word_data_received = data;
    word_received      = 1'b1;
    repeat (3) @(posedge CLK);
    #1;
    reply         = word_send_data;
    word_received = 1'b0;
    repeat (3) @(posedge CLK);
    #1;
  endtask

  task automatic read_status(input logic [7:0] addr, input logic [63:0] expected,
                             input string name);
    logic [63:0] reply;
    send_word({`CMD_STATUS_REG, 48'd0, addr}, reply);
    check_value(name, expected, reply);
  endtask

  task automatic write_config(input logic [7:0] addr, input logic [31:0] value,
                              output logic [63:0] old_value);
    logic [63:0] reply;
    send_word({`CMD_CONFIG_REG, 48'd0, addr}, old_value);
    send_word({32'd0, value}, reply);
    check_value("config write reply", 64'd0, reply);
  endtask

  task automatic wait_buffer_ready();
    while (!buffer_dtr)
      @(posedge CLK);
    #1;
  endtask

  task automatic wait_moves_done();
    while (done_count < accepted)
      @(posedge CLK);
    #1;
  endtask

  // fixed_dur of 0 picks a random duration
  task automatic random_move(input int fixed_dur, input bit expect_accept);
    logic [31:0]            r;
    logic [63:0]            reply;
    logic [`NUM_MOTORS-1:0] dirs;
    logic [31:0]            vel [`NUM_MOTORS];
    logic [31:0]            acc [`NUM_MOTORS];
    int                     dur;
    int                     steps;
    r    = next_random();
    dur  = (fixed_dur > 0) ? fixed_dur : 1 + int'(r % 20);
    dirs = r[8 +: `NUM_MOTORS];
    for (int i = 0; i < `NUM_MOTORS; i++) begin
      vel[i] = next_random() & 32'h7fff_ffff;
      r      = next_random();
      acc[i] = {{25{r[6]}}, r[6:0]};  // -64 to 63
    end
    send_word({`CMD_COORDINATED_STEP, {(`WORD_BITS - 8 - `NUM_MOTORS){1'b0}}, dirs}, reply);
    check_value("move header reply", 64'd0, reply);
    send_word(64'(dur), reply);
    check_value("move duration reply", 64'd0, reply);
    for (int i = 0; i < `NUM_MOTORS; i++) begin
      send_word({32'd0, vel[i]}, reply);
      check_value("move velocity reply", 64'd0, reply);
      send_word({32'd0, acc[i]}, reply);
      check_value("move accel reply", 64'd0, reply);
    end
    if (expect_accept) begin
      accepted++;
      for (int i = 0; i < `NUM_MOTORS; i++) begin
        steps        = dda_steps(vel[i], acc[i], dur);
        model_pos[i] = dirs[i] ? model_pos[i] + steps : model_pos[i] - steps;
      end
    end
  endtask

  task automatic check_motion(input string phase);
    for (int i = 0; i < `NUM_MOTORS; i++)
      check_value({phase, " step total"}, 64'(model_pos[i]), 64'(seen_steps[i]));
    check_value({phase, " move_done count"}, 64'(accepted), 64'(done_count));
    check_value({phase, " buffer_dtr after moves"}, 64'd1, 64'(buffer_dtr));
  endtask

  // Step and move_done monitor
  always @(negedge CLK) begin
    if (resetn) begin
      for (int i = 0; i < `NUM_MOTORS; i++)
        if (step[i])
          seen_steps[i] += dir_prev[i] ? 1 : -1;
      if (move_done)
        done_count++;
    end
    dir_prev = dir;
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      timeouts++;
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      finish_run();
    end
  end

  initial begin
    logic [63:0] old_value;
    logic [31:0] r;
    logic [`NUM_MOTORS-1:0] en_bits;
    CLK                = 1'b0;
    resetn             = 1'b0;
    word_received      = 1'b0;
    word_data_received = '0;
    rng_state          = 32'hed4e_d353;
    repeat (2) @(posedge CLK);
    #1 resetn = 1'b1;

    // Reset state and status map
    check_value("enable after reset", 64'd0, 64'(enable));
    check_value("buffer_dtr after reset", 64'd1, 64'(buffer_dtr));
    read_status(`STATUS_VERSION, 64'(`VERSION_WORD), "status version");
    read_status(`STATUS_CHANNEL_INFO, {48'd0, 8'(`POSITION_BITS), 8'(`NUM_MOTORS)},
                "status channel info");
    read_status(8'd9, 64'd0, "status unknown address");

    // Config round trip
    r       = next_random();
    en_bits = r[`NUM_MOTORS-1:0];
    write_config(`CONFIG_ENABLE, 32'(en_bits), old_value);
    check_value("enable before write", 64'd0, old_value);
    write_config(`CONFIG_CLOCKS, 32'd4, old_value);
    check_value("divisor before write", 64'(`DEFAULT_CLOCK_DIVISOR), old_value);
    write_config(`CONFIG_ENABLE, 32'(en_bits), old_value);
    check_value("enable read back", 64'(en_bits), old_value);
    write_config(`CONFIG_CLOCKS, 32'd4, old_value);
    check_value("divisor read back", 64'd4, old_value);
    check_value("enable output", 64'(en_bits), 64'(enable));

    // Each random move waits for buffer room
    for (int m = 0; m < 6; m++) begin
      wait_buffer_ready();
      random_move(0, 1'b1);
    end
    wait_moves_done();
    check_motion("random moves");

    // Fill both slots, then a move that must be dropped
    wait_buffer_ready();
    random_move(20, 1'b1);
    wait_buffer_ready();
    random_move(20, 1'b1);
    check_value("buffer_dtr with full buffer", 64'd0, 64'(buffer_dtr));
    random_move(0, 1'b0);
    wait_moves_done();
    repeat (DROP_WAIT_CYCLES) @(posedge CLK);  // Room for a wrongly taken move to finish
    #1;
    check_motion("back-pressure");

    for (int i = 0; i < `NUM_MOTORS; i++)
      read_status(8'(`STATUS_POSITION_START + i), 64'(model_pos[i]), "status position");
    finish_run();
  end

endmodule

// File: common/motion_cfg.svh
// Motion core configuration

`ifndef MOTION_CFG_SVH
`define MOTION_CFG_SVH

`define WORD_BITS             64
`define NUM_MOTORS            2
`define BUFFER_SIZE           2    // Power of two
`define MOVE_DURATION_BITS    32
`define DDA_BITS              32
`define POSITION_BITS         32

// Command codes in the header's top byte
`define CMD_COORDINATED_STEP  8'h01
`define CMD_STATUS_REG        8'hf1
`define CMD_CONFIG_REG        8'hf2

`define CONFIG_ENABLE         8'd0
`define CONFIG_CLOCKS         8'd1
`define DEFAULT_CLOCK_DIVISOR 8'd32

`define STATUS_VERSION        8'd0
`define STATUS_CHANNEL_INFO   8'd1
`define STATUS_POSITION_START 8'd2
`define VERSION_WORD          32'h0001_0200

`endif

// File: common/motion_pkg.sv
// Motion core shared types

`include "motion_cfg.svh"

package motion_pkg;

  typedef logic [`NUM_MOTORS-1:0] motor_vec_t;
  typedef logic [$clog2(`BUFFER_SIZE)-1:0] slot_idx_t;
  typedef logic signed [`DDA_BITS-1:0] dda_word_t;
  typedef logic signed [`POSITION_BITS-1:0] position_t;

  // Move header, direction bits at the bottom
  typedef struct packed {
    logic [7:0]                          cmd;
    logic [`WORD_BITS-8-`NUM_MOTORS-1:0] unused;
    motor_vec_t                          dir;
  } move_header_t;

  // Register access header
  typedef struct packed {
    logic [7:0]             cmd;
    logic [`WORD_BITS-17:0] unused;
    logic [7:0]             addr;
  } reg_header_t;

  typedef union packed {
    move_header_t move;
    reg_header_t  regs;
  } header_word_u;

endpackage

// File: dda/dda_axis_timer.sv
// Per-axis DDA step generator

`timescale 1ns/10ps
`include "motion_cfg.svh"

module dda_axis_timer (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  dda_tick,
  input  logic                  loading_move,
  input  logic                  executing_move,
  input  motion_pkg::dda_word_t velocity,
  input  motion_pkg::dda_word_t accel,
  input  logic                  dir,
  output logic                  step,
  output motion_pkg::position_t position
);

  import motion_pkg::*;

  dda_word_t            vel_q;
  dda_word_t            acc_q;
  dda_word_t            vel_next;
  logic [`DDA_BITS-1:0] accum;
  logic [`DDA_BITS:0]   accum_sum;  // Extra bit holds the carry
  logic                 advance;

  assign vel_next  = vel_q + acc_q;
  assign accum_sum = {1'b0, accum} + {1'b0, vel_next};
  assign advance   = dda_tick && executing_move;

  always_ff @(posedge CLK) begin
    if (loading_move) begin
      vel_q <= velocity;
      acc_q <= accel;
      accum <= '0;
    end else if (advance) begin
      vel_q <= vel_next;
      accum <= accum_sum[`DDA_BITS-1:0];
    end
  end

  // Carry out means one step
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      step     <= 1'b0;
      position <= '0;
    end else begin
      step <= advance && accum_sum[`DDA_BITS];
      if (advance && accum_sum[`DDA_BITS])
        position <= dir ? position + 1'b1 : position - 1'b1;
    end
  end

endmodule

// File: dda/dda_sequencer.sv
// DDA move sequencer

`timescale 1ns/10ps
`include "motion_cfg.svh"

module dda_sequencer (
  input  logic                           CLK,
  input  logic                           resetn,
  input  logic                           dda_tick,
  input  logic [`BUFFER_SIZE-1:0]        slot_ready,
  input  logic [`MOVE_DURATION_BITS-1:0] move_duration,
  output motion_pkg::slot_idx_t          move_slot,
  output logic [`BUFFER_SIZE-1:0]        buffer_free,
  output logic                           buffer_dtr,
  output logic                           loading_move,
  output logic                           executing_move,
  output logic                           move_done
);

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_LOAD,
    SEQ_RUN
  } seq_state_t;

  seq_state_t                     state;
  logic [`BUFFER_SIZE-1:0]        slot_taken;  // Consumed copy of slot_ready
  logic [`BUFFER_SIZE-1:0]        pending;
  logic [`MOVE_DURATION_BITS-1:0] remaining;

  // A slot stays pending until its move has finished
  assign pending        = slot_ready ^ slot_taken;
  assign buffer_free    = ~pending;
  assign buffer_dtr     = |buffer_free;
  assign loading_move   = (state == SEQ_LOAD);
  assign executing_move = (state == SEQ_RUN);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state      <= SEQ_IDLE;
      slot_taken <= '0;
      move_slot  <= '0;
      remaining  <= '0;
      move_done  <= 1'b0;
    end else begin
      move_done <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (pending[move_slot])
            state <= SEQ_LOAD;
        end
        SEQ_LOAD: begin
          remaining <= move_duration;
          state     <= SEQ_RUN;
        end
        SEQ_RUN: begin
          if (dda_tick) begin
            if (remaining <= 1) begin  // Last tick of the move
              state                 <= SEQ_IDLE;
              move_done             <= 1'b1;
              slot_taken[move_slot] <= slot_ready[move_slot];
              move_slot             <= move_slot + 1'b1;
            end else begin
              remaining <= remaining - 1'b1;
            end
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module motion_core_tb -Mdir obj_dir -o motion_core_sim \
  && ./obj_dir/motion_core_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "All checks passed" sim.log && exit 0 || exit 1

// File: src.f
+incdir+common
common/motion_pkg.sv
src/tick_divider.sv
src/word_command_parser.sv
dda/dda_sequencer.sv
dda/dda_axis_timer.sv
src/motion_core_top.sv
bench/motion_core_properties.sv
bench/motion_core_tb.sv

// File: src/motion_core_top.sv
// Stepper motion core top level

`timescale 1ns/10ps
`include "motion_cfg.svh"

module motion_core_top (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic [`WORD_BITS-1:0]  word_data_received,
  input  logic                   word_received,
  output logic [`WORD_BITS-1:0]  word_send_data,
  output motion_pkg::motor_vec_t step,
  output motion_pkg::motor_vec_t dir,
  output motion_pkg::motor_vec_t enable,
  output logic                   buffer_dtr,
  output logic                   move_done
);

  import motion_pkg::*;

  logic [7:0]                     divisor;
  logic                           dda_tick;
  logic [`BUFFER_SIZE-1:0]        slot_ready;
  logic [`BUFFER_SIZE-1:0]        buffer_free;
  slot_idx_t                      move_slot;
  logic [`MOVE_DURATION_BITS-1:0] move_duration;
  dda_word_t                      move_velocity [`NUM_MOTORS];
  dda_word_t                      move_accel [`NUM_MOTORS];
  position_t                      positions [`NUM_MOTORS];
  logic                           loading_move;
  logic                           executing_move;

  tick_divider divider_i (
    .CLK      (CLK),
    .resetn   (resetn),
    .divisor  (divisor),
    .dda_tick (dda_tick)
  );

  word_command_parser parser_i (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .buffer_free        (buffer_free),
    .move_slot          (move_slot),
    .positions          (positions),
    .word_send_data     (word_send_data),
    .enable             (enable),
    .divisor            (divisor),
    .slot_ready         (slot_ready),
    .move_dir           (dir),  // Direction of the executing slot
    .move_duration      (move_duration),
    .move_velocity      (move_velocity),
    .move_accel         (move_accel)
  );

  dda_sequencer sequencer_i (
    .CLK            (CLK),
    .resetn         (resetn),
    .dda_tick       (dda_tick),
    .slot_ready     (slot_ready),
    .move_duration  (move_duration),
    .move_slot      (move_slot),
    .buffer_free    (buffer_free),
    .buffer_dtr     (buffer_dtr),
    .loading_move   (loading_move),
    .executing_move (executing_move),
    .move_done      (move_done)
  );

  for (genvar i = 0; i < `NUM_MOTORS; i++) begin : g_axis
    dda_axis_timer axis_i (
      .CLK            (CLK),
      .resetn         (resetn),
      .dda_tick       (dda_tick),
      .loading_move   (loading_move),
      .executing_move (executing_move),
      .velocity       (move_velocity[i]),
      .accel          (move_accel[i]),
      .dir            (dir[i]),
      .step           (step[i]),
      .position       (positions[i])
    );
  end

endmodule

// File: src/tick_divider.sv
// DDA tick divider

`timescale 1ns/10ps

module tick_divider (
  input  logic       CLK,
  input  logic       resetn,
  input  logic [7:0] divisor,
  output logic       dda_tick
);

  logic [7:0] count;
  logic [7:0] period;

  assign period = (divisor < 8'd2) ? 8'd2 : divisor;  // Clamp to a minimum of 2

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      count    <= 8'd0;
      dda_tick <= 1'b0;
    end else begin
      dda_tick <= (count == 8'd0);
      count    <= (count == 8'd0) ? period - 8'd1 : count - 8'd1;
    end
  end

endmodule

// File: src/word_command_parser.sv
// Host word command parser

`timescale 1ns/10ps
`include "motion_cfg.svh"

module word_command_parser (
  input  logic                           CLK,
  input  logic                           resetn,
  input  logic [`WORD_BITS-1:0]          word_data_received,
  input  logic                           word_received,
  input  logic [`BUFFER_SIZE-1:0]        buffer_free,
  input  motion_pkg::slot_idx_t          move_slot,
  input  motion_pkg::position_t          positions [`NUM_MOTORS],
  output logic [`WORD_BITS-1:0]          word_send_data,
  output motion_pkg::motor_vec_t         enable,
  output logic [7:0]                     divisor,
  output logic [`BUFFER_SIZE-1:0]        slot_ready,
  output motion_pkg::motor_vec_t         move_dir,
  output logic [`MOVE_DURATION_BITS-1:0] move_duration,
  output motion_pkg::dda_word_t          move_velocity [`NUM_MOTORS],
  output motion_pkg::dda_word_t          move_accel [`NUM_MOTORS]
);

  import motion_pkg::*;

  logic [2:0]   rx_sync;           // Strobe sampling chain
  logic         rise;
  header_word_u hdr_in;
  header_word_u hdr_q;             // Header of the message in progress
  logic         busy;
  logic [7:0]   word_count;
  logic         move_accept;
  slot_idx_t    write_slot;
  logic         last_move_word;
  logic         move_start;
  logic         move_word;
  logic [`WORD_BITS-1:0] status_word;
  logic [`WORD_BITS-1:0] config_word;

  // Slot storage
  motor_vec_t                     dir_mem [`BUFFER_SIZE];
  logic [`MOVE_DURATION_BITS-1:0] dur_mem [`BUFFER_SIZE];
  dda_word_t                      vel_mem [`BUFFER_SIZE][`NUM_MOTORS];
  dda_word_t                      acc_mem [`BUFFER_SIZE][`NUM_MOTORS];

  assign rise           = rx_sync[1] & ~rx_sync[2];
  assign hdr_in         = word_data_received;
  assign last_move_word = (word_count == 8'(2 * `NUM_MOTORS + 1));
  assign move_start     = rise && !busy && (hdr_in.move.cmd == `CMD_COORDINATED_STEP);
  assign move_word      = rise && busy && move_accept &&
                          (hdr_q.move.cmd == `CMD_COORDINATED_STEP);

  // Executing slot seen by the sequencer and the axes
  assign move_dir      = dir_mem[move_slot];
  assign move_duration = dur_mem[move_slot];
  always_comb begin
    for (int i = 0; i < `NUM_MOTORS; i++) begin
      move_velocity[i] = vel_mem[move_slot][i];
      move_accel[i]    = acc_mem[move_slot][i];
    end
  end

  always_comb begin
    status_word = '0;
    if (hdr_in.regs.addr == `STATUS_VERSION) begin
      status_word[31:0] = `VERSION_WORD;
    end else if (hdr_in.regs.addr == `STATUS_CHANNEL_INFO) begin
      status_word[7:0]  = 8'(`NUM_MOTORS);
      status_word[15:8] = 8'(`POSITION_BITS);
    end
    for (int i = 0; i < `NUM_MOTORS; i++) begin
      if (hdr_in.regs.addr == `STATUS_POSITION_START + i)
        status_word = `WORD_BITS'(positions[i]);  // Sign extended
    end
  end

  always_comb begin
    config_word = '0;
    case (hdr_in.regs.addr)
      `CONFIG_ENABLE: config_word[`NUM_MOTORS-1:0] = enable;
      `CONFIG_CLOCKS: config_word[7:0] = divisor;
      default: ;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (move_start && buffer_free[write_slot])
      dir_mem[write_slot] <= hdr_in.move.dir;
    if (move_word) begin
      if (word_count == 8'd1)
        dur_mem[write_slot] <= word_data_received[`MOVE_DURATION_BITS-1:0];
      for (int i = 0; i < `NUM_MOTORS; i++) begin
        if (word_count == 8'(2 + 2 * i))
          vel_mem[write_slot][i] <= word_data_received[`DDA_BITS-1:0];
        if (word_count == 8'(3 + 2 * i))
          acc_mem[write_slot][i] <= word_data_received[`DDA_BITS-1:0];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      rx_sync        <= '0;
      word_send_data <= '0;
      hdr_q          <= '0;
      busy           <= 1'b0;
      word_count     <= 8'd0;
      move_accept    <= 1'b0;
      write_slot     <= '0;
      slot_ready     <= '0;
      enable         <= '0;
      divisor        <= `DEFAULT_CLOCK_DIVISOR;
    end else begin
      rx_sync <= {rx_sync[1:0], word_received};
      if (rise) begin
        word_send_data <= '0;  // Default reply
        if (!busy) begin
          hdr_q      <= hdr_in;
          word_count <= 8'd1;
          case (hdr_in.move.cmd)
            `CMD_COORDINATED_STEP: begin
              busy        <= 1'b1;
              move_accept <= buffer_free[write_slot];  // Full buffer drops the move
            end
            `CMD_STATUS_REG: word_send_data <= status_word;
            `CMD_CONFIG_REG: begin
              busy           <= 1'b1;
              word_send_data <= config_word;
            end
            default: ;
          endcase
        end else begin
          word_count <= word_count + 8'd1;
          if (hdr_q.regs.cmd == `CMD_CONFIG_REG) begin
            busy <= 1'b0;
            if (hdr_q.regs.addr == `CONFIG_ENABLE)
              enable <= word_data_received[`NUM_MOTORS-1:0];
            else if (hdr_q.regs.addr == `CONFIG_CLOCKS)
              divisor <= word_data_received[7:0];
          end else if (last_move_word) begin
            busy <= 1'b0;
            if (move_accept) begin
              // Hand the slot to the sequencer
              slot_ready[write_slot] <= ~slot_ready[write_slot];
              write_slot             <= write_slot + 1'b1;
            end
          end
        end
      end
    end
  end

endmodule
